// File: rtl/pb_ilv_defines.svh
`ifndef PB_ILV_DEFINES_SVH
`define PB_ILV_DEFINES_SVH

// ----------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------
`define PB_ILV_SYM_W        2      // one 2-bit symbol
`define PB_ILV_ADDR_W       12     // linear block address / pb_len
`define PB_ILV_OFF_W        10     // offset inside a quarter, cycle count
`define PB_ILV_LANES        4

// ----------------------------------------------------------------------
// block sizes, pb_len codes in symbols
// ----------------------------------------------------------------------
`define PB_ILV_LEN_16       64
`define PB_ILV_LEN_136      544
`define PB_ILV_LEN_520      2080

// quarter lengths
`define PB_ILV_Q_16         16
`define PB_ILV_Q_136        136
`define PB_ILV_Q_520        520

// ----------------------------------------------------------------------
// stride walk, dint stride is the inverse of int stride mod Q
// ----------------------------------------------------------------------
`define PB_ILV_STRIDE_INT_16    5
`define PB_ILV_STRIDE_INT_136   11
`define PB_ILV_STRIDE_INT_520   7

`define PB_ILV_STRIDE_DINT_16   13   // 5 * 13 = 65 = 4*16 + 1
`define PB_ILV_STRIDE_DINT_136  99
`define PB_ILV_STRIDE_DINT_520  223

`define PB_ILV_BANK_DEPTH   520    // largest quarter

`endif

// File: rtl/pb_ilv_pkg.sv
`include "pb_ilv_defines.svh"

package pb_ilv_pkg;

    // symbol on the write port and on every lane
    typedef logic [`PB_ILV_SYM_W-1:0]   sym_t;

    // linear address within a block, also used for pb_len
    typedef logic [`PB_ILV_ADDR_W-1:0]  addr_t;

    // offset within a quarter bank
    typedef logic [`PB_ILV_OFF_W-1:0]   off_t;

    // lane / port index and rotation
    typedef logic [$clog2(`PB_ILV_LANES)-1:0] lane_t;

    // read controller
    typedef enum logic {
        IDLE = 1'b0,
        READ = 1'b1
    } ctrl_state_t;

endpackage

// File: rtl/pb_ilv_ctrl.sv
`timescale 1ns/1ps
`include "pb_ilv_defines.svh"

module pb_ilv_ctrl import pb_ilv_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        start,
    input  addr_t       pb_len,
    input  logic        mod_int_dint,   // 1 interleave, 0 deinterleave
    output off_t        q_len,
    output logic        busy,
    output logic        rd_en,
    output off_t        rd_off,
    output lane_t       rot,
    output logic        mode
);

    ctrl_state_t state;

    off_t q_dec;
    off_t stride_dec;
    logic len_ok;

    off_t q_lat;
    off_t stride_lat;
    off_t cnt;          // read cycle c
    off_t off_sum;
    logic accept;
    logic last;

    // ------------------------------------------------------------------
    // pb_len decode
    // ------------------------------------------------------------------
    always_comb begin
        q_dec      = '0;
        stride_dec = '0;
        len_ok     = 1'b0;
        case (pb_len)
            addr_t'(`PB_ILV_LEN_16): begin
                q_dec      = off_t'(`PB_ILV_Q_16);
                stride_dec = mod_int_dint ? off_t'(`PB_ILV_STRIDE_INT_16)
                                          : off_t'(`PB_ILV_STRIDE_DINT_16);
                len_ok     = 1'b1;
            end
            addr_t'(`PB_ILV_LEN_136): begin
                q_dec      = off_t'(`PB_ILV_Q_136);
                stride_dec = mod_int_dint ? off_t'(`PB_ILV_STRIDE_INT_136)
                                          : off_t'(`PB_ILV_STRIDE_DINT_136);
                len_ok     = 1'b1;
            end
            addr_t'(`PB_ILV_LEN_520): begin
                q_dec      = off_t'(`PB_ILV_Q_520);
                stride_dec = mod_int_dint ? off_t'(`PB_ILV_STRIDE_INT_520)
                                          : off_t'(`PB_ILV_STRIDE_DINT_520);
                len_ok     = 1'b1;
            end
            default: ;  // unsupported, start is ignored
        endcase
    end

    assign accept  = (state == IDLE) && start && len_ok;
    assign last    = (cnt == q_lat - off_t'(1));
    assign off_sum = rd_off + stride_lat;   // stride < Q, one subtract is enough

    // ------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (accept) state <= READ;
                READ:    if (last) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // counter and stride walk
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            q_lat      <= '0;
            stride_lat <= '0;
            mode       <= 1'b0;
            cnt        <= '0;
            rd_off     <= '0;
        end else if (accept) begin
            q_lat      <= q_dec;
            stride_lat <= stride_dec;
            mode       <= mod_int_dint;
            cnt        <= '0;
            rd_off     <= '0;
        end else if (state == READ) begin
            if (last) begin
                cnt    <= '0;
                rd_off <= '0;
            end else begin
                cnt    <= cnt + off_t'(1);
                rd_off <= (off_sum >= q_lat) ? off_sum - q_lat : off_sum;
            end
        end
    end

    assign busy  = (state == READ);
    assign rd_en = busy;
    assign rot   = lane_t'(cnt);    // c mod 4

    // write path needs Q before the run starts
    assign q_len = (state == IDLE) ? q_dec : q_lat;

endmodule

// File: rtl/pb_ilv_bank_store.sv
`timescale 1ns/1ps
`include "pb_ilv_defines.svh"

module pb_ilv_bank_store import pb_ilv_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    // write side
    input  logic        wen,
    input  addr_t       waddr,
    input  sym_t        wdata,
    input  off_t        q_len,
    // read side
    input  logic        rd_en,
    input  off_t        rd_off,
    input  lane_t       rot,
    input  logic        mode,
    output sym_t        lane0,
    output sym_t        lane1,
    output sym_t        lane2,
    output sym_t        lane3,
    output logic        lane_vld,
    output lane_t       lane_rot,
    output logic        lane_mode
);

    addr_t q1;
    addr_t q2;
    addr_t q3;
    addr_t wr_base;
    addr_t wr_rel;
    lane_t wr_bank;
    off_t  wr_off;
    logic  wr_ok;

    sym_t  rd_q [`PB_ILV_LANES];

    // ------------------------------------------------------------------
    // linear write decode
    // ------------------------------------------------------------------
    assign q1 = addr_t'(q_len);
    assign q2 = q1 << 1;
    assign q3 = q2 + q1;

    always_comb begin
        if (waddr >= q3) begin
            wr_bank = lane_t'(3);
            wr_base = q3;
        end else if (waddr >= q2) begin
            wr_bank = lane_t'(2);
            wr_base = q2;
        end else if (waddr >= q1) begin
            wr_bank = lane_t'(1);
            wr_base = q1;
        end else begin
            wr_bank = lane_t'(0);
            wr_base = '0;
        end
    end

    assign wr_rel = waddr - wr_base;
    assign wr_off = off_t'(wr_rel);
    assign wr_ok  = wen && (wr_rel < q1);   // drops addresses past the block

    // ------------------------------------------------------------------
    // quarter banks
    // ------------------------------------------------------------------
    for (genvar k = 0; k < `PB_ILV_LANES; k++) begin : g_bank
        sym_t mem [`PB_ILV_BANK_DEPTH];

        always_ff @(posedge clk) begin
            if (wr_ok && (wr_bank == lane_t'(k)))
                mem[wr_off] <= wdata;
            if (rd_en)
                rd_q[k] <= mem[rd_off];     // same offset in all banks
        end
    end

    // sideband follows the data
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            lane_vld  <= 1'b0;
            lane_rot  <= '0;
            lane_mode <= 1'b0;
        end else begin
            lane_vld  <= rd_en;
            lane_rot  <= rot;
            lane_mode <= mode;
        end
    end

    assign lane0 = rd_q[0];
    assign lane1 = rd_q[1];
    assign lane2 = rd_q[2];
    assign lane3 = rd_q[3];

endmodule

// File: rtl/pb_ilv_lane_router.sv
`timescale 1ns/1ps
`include "pb_ilv_defines.svh"

module pb_ilv_lane_router import pb_ilv_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  sym_t        lane0,
    input  sym_t        lane1,
    input  sym_t        lane2,
    input  sym_t        lane3,
    input  logic        lane_vld,
    input  lane_t       lane_rot,
    input  logic        lane_mode,  // 1 interleave
    output sym_t        rdata0,
    output sym_t        rdata1,
    output sym_t        rdata2,
    output sym_t        rdata3,
    output logic        dout_vld
);

    sym_t  lanes [`PB_ILV_LANES];
    sym_t  port_q [`PB_ILV_LANES];
    lane_t sel [`PB_ILV_LANES];

    assign lanes[0] = lane0;
    assign lanes[1] = lane1;
    assign lanes[2] = lane2;
    assign lanes[3] = lane3;

    // ------------------------------------------------------------------
    // port p takes lane p - rot (int) or p + rot (dint)
    // ------------------------------------------------------------------
    always_comb begin
        for (int p = 0; p < `PB_ILV_LANES; p++) begin
            if (lane_mode)
                sel[p] = lane_t'(p) - lane_rot;
            else
                sel[p] = lane_t'(p) + lane_rot;   // wraps mod 4
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int p = 0; p < `PB_ILV_LANES; p++)
                port_q[p] <= '0;
        end else if (lane_vld) begin
            for (int p = 0; p < `PB_ILV_LANES; p++)
                port_q[p] <= lanes[sel[p]];
        end
    end

    // valid at the crossbar output
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst)
            dout_vld <= 1'b0;
        else
            dout_vld <= lane_vld;
    end

    assign rdata0 = port_q[0];
    assign rdata1 = port_q[1];
    assign rdata2 = port_q[2];
    assign rdata3 = port_q[3];

endmodule

// File: rtl/pb_ilv_top.sv
`timescale 1ns/1ps

module pb_ilv_top import pb_ilv_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        wen,
    input  addr_t       waddr,
    input  sym_t        wdata,
    input  addr_t       pb_len,
    input  logic        start,
    input  logic        mod_int_dint,
    output sym_t        rdata0,
    output sym_t        rdata1,
    output sym_t        rdata2,
    output sym_t        rdata3,
    output logic        dout_vld,
    output logic        busy
);

    // controller to banks
    off_t  q_len;
    logic  rd_en;
    off_t  rd_off;
    lane_t rot;
    logic  mode;

    // banks to router
    sym_t  lane0;
    sym_t  lane1;
    sym_t  lane2;
    sym_t  lane3;
    logic  lane_vld;
    lane_t lane_rot;
    logic  lane_mode;

    pb_ilv_ctrl pb_ilv_ctrl_inst (
        .clk          (clk),
        .n_rst        (n_rst),
        .start        (start),
        .pb_len       (pb_len),
        .mod_int_dint (mod_int_dint),
        .q_len        (q_len),
        .busy         (busy),
        .rd_en        (rd_en),
        .rd_off       (rd_off),
        .rot          (rot),
        .mode         (mode)
    );

    pb_ilv_bank_store pb_ilv_bank_store_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata),
        .q_len     (q_len),
        .rd_en     (rd_en),
        .rd_off    (rd_off),
        .rot       (rot),
        .mode      (mode),
        .lane0     (lane0),
        .lane1     (lane1),
        .lane2     (lane2),
        .lane3     (lane3),
        .lane_vld  (lane_vld),
        .lane_rot  (lane_rot),
        .lane_mode (lane_mode)
    );

    pb_ilv_lane_router pb_ilv_lane_router_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .lane0     (lane0),
        .lane1     (lane1),
        .lane2     (lane2),
        .lane3     (lane3),
        .lane_vld  (lane_vld),
        .lane_rot  (lane_rot),
        .lane_mode (lane_mode),
        .rdata0    (rdata0),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .rdata3    (rdata3),
        .dout_vld  (dout_vld)
    );

endmodule

// File: sim/pb_ilv_sva.sv
`timescale 1ns/1ps

module pb_ilv_sva import pb_ilv_pkg::*; (
    input logic clk,
    input logic n_rst,
    input logic busy,
    input logic dout_vld,
    input off_t q_len,
    input off_t rd_off
);

    logic [11:0] busy_cnt;     // cycles busy has been high in this run

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst)
            busy_cnt <= '0;
        else if (busy)
            busy_cnt <= busy_cnt + 12'd1;
        else
            busy_cnt <= '0;
    end

    // ----------------------------------------------------------------------
    // controller protocol
    // ----------------------------------------------------------------------
    property p_busy_len;
        @(posedge clk) disable iff (!n_rst)
        $fell(busy) |-> (busy_cnt == {2'b00, $past(q_len)});
    endproperty

    property p_vld_lag;
        @(posedge clk) disable iff (!n_rst)
        $rose(busy) |-> ##2 $rose(dout_vld);
    endproperty

    property p_off_range;
        @(posedge clk) disable iff (!n_rst)
        busy |-> (rd_off < q_len);
    endproperty

    a_busy_len:  assert property (p_busy_len)
        else $error("busy run length differs from q_len");
    a_vld_lag:   assert property (p_vld_lag)
        else $error("dout_vld did not rise two cycles after busy");
    a_off_range: assert property (p_off_range)
        else $error("rd_off outside the quarter");

endmodule

bind pb_ilv_top pb_ilv_sva pb_ilv_sva_inst (
    .clk      (clk),
    .n_rst    (n_rst),
    .busy     (busy),
    .dout_vld (dout_vld),
    .q_len    (q_len),
    .rd_off   (rd_off)
);

// File: sim/pb_ilv_tb.sv
`timescale 1ns/1ps
`include "pb_ilv_defines.svh"

module pb_ilv_tb import pb_ilv_pkg::*; ();

    logic  clk;
    logic  n_rst;
    logic  wen;
    addr_t waddr;
    sym_t  wdata;
    addr_t pb_len;
    logic  start;
    logic  mod_int_dint;
    sym_t  rdata0;
    sym_t  rdata1;
    sym_t  rdata2;
    sym_t  rdata3;
    logic  dout_vld;
    logic  busy;

    sym_t       blk [`PB_ILV_LEN_520];     // image of the block last written
    logic [7:0] exp_q [$];                 // port p at bits 2p+1:2p
    int         vld_count;

    pb_ilv_top pb_ilv_top_inst (
        .clk          (clk),
        .n_rst        (n_rst),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .pb_len       (pb_len),
        .start        (start),
        .mod_int_dint (mod_int_dint),
        .rdata0       (rdata0),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .rdata3       (rdata3),
        .dout_vld     (dout_vld),
        .busy         (busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_sym(input string name, input sym_t got, input sym_t exp);
        assert (got === exp)
            else stop_on_error($sformatf("MISMATCH %s expected %h got %h", name, exp, got));
    endtask

    function automatic int int_stride(input int q);
        case (q)
            `PB_ILV_Q_16:  return `PB_ILV_STRIDE_INT_16;
            `PB_ILV_Q_136: return `PB_ILV_STRIDE_INT_136;
            default:       return `PB_ILV_STRIDE_INT_520;
        endcase
    endfunction

    // modular inverse by search
    function automatic int inv_mod(input int s, input int q);
        int r;
        r = 0;
        for (int i = 1; i < q; i++)
            if ((s * i) % q == 1)
                r = i;
        return r;
    endfunction

    task automatic write_block(input addr_t len);
        sym_t d;
        pb_len = len;
        for (int a = 0; a < int'(len); a++) begin
            d     = sym_t'($urandom);
            wen   = 1'b1;
            waddr = addr_t'(a);
            wdata = d;
            blk[a] = d;
            @(negedge clk);
        end
        wen = 1'b0;
    endtask

    // stride walk plus rotation for each read cycle
    task automatic queue_expected(input int q, input bit ilv);
        int stride;
        int off;
        int port;
        logic [7:0] word;
        stride = ilv ? int_stride(q) : inv_mod(int_stride(q), q);
        off = 0;
        for (int c = 0; c < q; c++) begin
            word = '0;
            for (int k = 0; k < 4; k++) begin
                port = ilv ? (k + c) % 4 : (k + 4 - c % 4) % 4;
                word[2*port +: 2] = blk[k*q + off];
            end
            exp_q.push_back(word);
            off = (off + stride) % q;
        end
    endtask

    task automatic pulse_start(input bit ilv);
        mod_int_dint = ilv;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (busy || dout_vld) begin
            if (n >= limit)
                stop_on_error("timeout waiting for the read to drain");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_block(input addr_t len, input bit ilv, input bit poke);
        int q;
        int n;
        int base;
        q    = int'(len) / 4;
        base = vld_count;
        queue_expected(q, ilv);
        pulse_start(ilv);
        n = 1;
        while (!dout_vld) begin
            if (n >= 20)
                stop_on_error("timeout waiting for the first dout_vld");
            @(negedge clk);
            n++;
        end
        assert (n == 3)
            else stop_on_error($sformatf("first dout_vld came %0d cycles after accept", n - 1));
        if (poke) begin
            pulse_start(!ilv);     // ignored while the run is in progress
            mod_int_dint = ilv;
        end
        wait_idle(q + 20);
        assert (vld_count - base == q)
            else stop_on_error($sformatf("MISMATCH dout_vld_count expected %h got %h",
                                         q, vld_count - base));
    endtask

    task automatic run_back_to_back(input addr_t len);
        int q;
        int n;
        int base;
        q    = int'(len) / 4;
        base = vld_count;
        queue_expected(q, 1'b1);
        pulse_start(1'b1);
        n = 0;
        while (busy) begin
            if (n >= q + 20)
                stop_on_error("timeout waiting for busy to fall");
            @(negedge clk);
            n++;
        end
        queue_expected(q, 1'b0);   // restart while the first run drains
        pulse_start(1'b0);
        wait_idle(q + 20);
        assert (vld_count - base == 2 * q)
            else stop_on_error($sformatf("MISMATCH dout_vld_count expected %h got %h",
                                         2 * q, vld_count - base));
    endtask

    // ----------------------------------------------------------------------
    // output monitor
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        logic [7:0] word;
        if (n_rst && dout_vld) begin
            assert (exp_q.size() > 0)
                else stop_on_error("dout_vld high with no output expected");
            word = exp_q.pop_front();
            check_sym("rdata0", rdata0, word[1:0]);
            check_sym("rdata1", rdata1, word[3:2]);
            check_sym("rdata2", rdata2, word[5:4]);
            check_sym("rdata3", rdata3, word[7:6]);
            vld_count++;
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h39320914));
        n_rst        = 1'b0;
        wen          = 1'b0;
        waddr        = '0;
        wdata        = '0;
        pb_len       = addr_t'(`PB_ILV_LEN_16);
        start        = 1'b0;
        mod_int_dint = 1'b1;
        vld_count    = 0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // reset values
        assert (!busy && !dout_vld)
            else stop_on_error("busy or dout_vld high after reset");
        check_sym("rdata0", rdata0, '0);
        check_sym("rdata1", rdata1, '0);
        check_sym("rdata2", rdata2, '0);
        check_sym("rdata3", rdata3, '0);

        // each size in interleave then deinterleave mode
        write_block(addr_t'(`PB_ILV_LEN_16));
        run_block(addr_t'(`PB_ILV_LEN_16), 1'b1, 1'b0);
        run_block(addr_t'(`PB_ILV_LEN_16), 1'b0, 1'b0);
        write_block(addr_t'(`PB_ILV_LEN_136));
        run_block(addr_t'(`PB_ILV_LEN_136), 1'b1, 1'b0);
        run_block(addr_t'(`PB_ILV_LEN_136), 1'b0, 1'b0);
        write_block(addr_t'(`PB_ILV_LEN_520));
        run_block(addr_t'(`PB_ILV_LEN_520), 1'b1, 1'b0);
        run_block(addr_t'(`PB_ILV_LEN_520), 1'b0, 1'b0);

        // unsupported length
        pb_len = addr_t'(100);
        pulse_start(1'b1);
        repeat (6) begin
            assert (!busy && !dout_vld)
                else stop_on_error("start with unsupported pb_len was accepted");
            @(negedge clk);
        end

        // stray start during a run
        write_block(addr_t'(`PB_ILV_LEN_136));
        run_block(addr_t'(`PB_ILV_LEN_136), 1'b1, 1'b1);
        run_block(addr_t'(`PB_ILV_LEN_136), 1'b0, 1'b1);

        write_block(addr_t'(`PB_ILV_LEN_16));
        run_back_to_back(addr_t'(`PB_ILV_LEN_16));
        write_block(addr_t'(`PB_ILV_LEN_136));
        run_back_to_back(addr_t'(`PB_ILV_LEN_136));

        if (exp_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_on_error("expected outputs left unchecked at end of run");
        end
    end

endmodule

// File: pb_ilv.f
+incdir+rtl
rtl/pb_ilv_pkg.sv
rtl/pb_ilv_ctrl.sv
rtl/pb_ilv_bank_store.sv
rtl/pb_ilv_lane_router.sv
rtl/pb_ilv_top.sv
sim/pb_ilv_sva.sv
sim/pb_ilv_tb.sv
